/* auth_proto_pkg.sv */
package auth_proto_pkg;

	////////////////////////////////////////////////////////////
	// Session states
	////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		idle         = 5'd0,		// Waiting for en
		int_start    = 5'd1,		// Ask the processor to open a session
		trng         = 5'd2,		// Device nonce from the TRNG
		shuf_dev     = 5'd3,		// Device nonce keyed with itself
		wait_serv    = 5'd4,		// Server nonce on data_in1
		shuf_serv    = 5'd5,		// Server nonce keyed with itself
		int_nonce    = 5'd6,		// Device nonce is on data_out
		wait_chal    = 5'd7,		// Challenge and check word from the server
		deshuf_chal  = 5'd8,
		chal_gen     = 5'd9,		// LFSR steps
		deshuf_check = 5'd10,
		validate     = 5'd11,		// Server check
		puf          = 5'd12,		// PUF evaluation
		shuf_resp    = 5'd13,		// Masked response keyed with the server nonce
		int_resp     = 5'd14		// Response is on data_out
	} state_t;

	////////////////////////////////////////////////////////////
	// Processor messages and fixed output words
	////////////////////////////////////////////////////////////

	typedef logic [1:0] msg_t;
	localparam msg_t msg_ok    = 2'b01;		// Server data is in place
	localparam msg_t msg_abort = 2'b11;		// Server timed out

	localparam crypto_pkg::word_t init_packet  = {32{2'b10}};
	localparam crypto_pkg::word_t success_word = 64'd65535;

endpackage

/* auth_sequencer.sv */
`timescale 1ns/1ns

module auth_sequencer #(
	parameter int chal_steps = 1
) (
	input  logic                   mclk,
	input  logic                   rst,
	input  logic                   en,
	input  auth_proto_pkg::msg_t   ps_msg,
	input  logic                   puf_done,
	input  logic                   shuf_done,
	input  logic                   success,
	output auth_proto_pkg::state_t cur_state,
	output logic                   shuf_start,
	output logic                   deshuffle,
	output logic                   trng_trig,
	output logic                   puf_en,
	output logic                   interrupt1,
	output logic                   interrupt2
);
	import auth_proto_pkg::*;

	localparam int cnt_w = (chal_steps > 1) ? $clog2(chal_steps) : 1;
	localparam logic [cnt_w-1:0] last_step = cnt_w'(chal_steps - 1);

	state_t           next_state;
	state_t           prev_state;		// For state entry detection
	logic [cnt_w-1:0] step_cnt;			// Cycles spent in chal_gen
	logic             in_shuf;			// State that uses the shuffler
	logic             entered;			// First cycle in the current state
	logic             shuf_busy;		// Between shuf_start and shuf_done

	assign in_shuf = (cur_state == shuf_dev) || (cur_state == shuf_serv) ||
		(cur_state == deshuf_chal) || (cur_state == deshuf_check) ||
		(cur_state == shuf_resp);
	assign entered = (cur_state != prev_state);

	////////////////////////////////////////////////////////////
	// Session FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge mclk or posedge rst)
	begin
		if (rst)
		begin
			cur_state  <= idle;
			prev_state <= idle;
		end
		else
		begin
			cur_state  <= next_state;
			prev_state <= cur_state;
		end
	end

	always_comb
	begin
		next_state = cur_state;		// Hold by default
		case (cur_state)
			idle:         if (en) next_state = int_start;
			int_start:    next_state = trng;
			trng:         if (puf_done) next_state = shuf_dev;		// TRNG shares the done line
			shuf_dev:     if (shuf_done) next_state = wait_serv;
			wait_serv:
			begin
				if (ps_msg == msg_ok)
					next_state = shuf_serv;
				else if (ps_msg == msg_abort)
					next_state = idle;
			end
			shuf_serv:    if (shuf_done) next_state = int_nonce;
			int_nonce:    next_state = wait_chal;
			wait_chal:
			begin
				if (ps_msg == msg_ok)
					next_state = deshuf_chal;
				else if (ps_msg == msg_abort)
					next_state = idle;
			end
			deshuf_chal:  if (shuf_done) next_state = chal_gen;
			chal_gen:     if (step_cnt == last_step) next_state = deshuf_check;
			deshuf_check: if (shuf_done) next_state = validate;
			validate:     next_state = success ? puf : idle;		// Failed check ends the session
			puf:          if (puf_done) next_state = shuf_resp;
			shuf_resp:    if (shuf_done) next_state = int_resp;
			int_resp:     next_state = idle;
			default:      next_state = idle;
		endcase
	end

	// LFSR step counter
	always_ff @(posedge mclk or posedge rst)
	begin
		if (rst)
			step_cnt <= '0;
		else if (cur_state == chal_gen)
			step_cnt <= step_cnt + 1'b1;
		else
			step_cnt <= '0;
	end

	////////////////////////////////////////////////////////////
	// Pulses and interrupts
	////////////////////////////////////////////////////////////

	always_ff @(posedge mclk or posedge rst)
	begin
		if (rst)
		begin
			shuf_start <= 1'b0;
			deshuffle  <= 1'b0;
			trng_trig  <= 1'b0;
			puf_en     <= 1'b0;
			interrupt1 <= 1'b0;
			interrupt2 <= 1'b0;
		end
		else
		begin
			shuf_start <= in_shuf && entered;		// Operands settle in the first cycle
			deshuffle  <= (cur_state == deshuf_chal) || (cur_state == deshuf_check);
			trng_trig  <= (next_state == trng) && (cur_state != trng);		// High on entry
			puf_en     <= (cur_state == puf) && entered;
			interrupt1 <= (cur_state == int_start) || (cur_state == validate);
			interrupt2 <= (cur_state == int_nonce) || (cur_state == int_resp);
		end
	end

	// Shuffler occupancy
	always_ff @(posedge mclk or posedge rst)
	begin
		if (rst)
			shuf_busy <= 1'b0;
		else if (shuf_start)
			shuf_busy <= 1'b1;
		else if (shuf_done)
			shuf_busy <= 1'b0;
	end

	// No restart of the shuffler before its done
	a_start_not_busy: assert property (@(posedge mclk) disable iff (rst)
		shuf_start |-> !shuf_busy);

	// Each interrupt is a lone single-cycle pulse
	a_one_interrupt: assert property (@(posedge mclk) disable iff (rst)
		(interrupt1 || interrupt2) |=> !(interrupt1 || interrupt2));

endmodule

/* auth_top.sv */
`timescale 1ns/1ns

module auth_top #(
	parameter int chal_steps = 1		// LFSR steps per challenge
) (
	input  logic                 mclk,
	input  logic                 rst,
	input  logic                 en,
	input  auth_proto_pkg::msg_t ps_msg,
	input  crypto_pkg::word_t    data_in1,
	input  crypto_pkg::word_t    data_in2,
	input  crypto_pkg::word_t    resp_in,
	input  crypto_pkg::word_t    trng_in,
	input  logic                 puf_done,
	output logic                 puf_en,
	output logic                 trng_trig,
	output logic                 interrupt1,
	output logic                 interrupt2,
	output crypto_pkg::word_t    challenge,
	output crypto_pkg::word_t    data_out
);
	import auth_proto_pkg::*;
	import crypto_pkg::*;

	state_t cur_state;
	logic   shuf_start;
	logic   deshuffle;
	logic   shuf_done;
	logic   success;
	word_t  shuf_data;
	word_t  shuf_key;
	word_t  shuf_out;

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	auth_sequencer #(.chal_steps(chal_steps)) i_auth_sequencer (
		.mclk       (mclk),
		.rst        (rst),
		.en         (en),
		.ps_msg     (ps_msg),
		.puf_done   (puf_done),
		.shuf_done  (shuf_done),
		.success    (success),
		.cur_state  (cur_state),
		.shuf_start (shuf_start),
		.deshuffle  (deshuffle),
		.trng_trig  (trng_trig),
		.puf_en     (puf_en),
		.interrupt1 (interrupt1),
		.interrupt2 (interrupt2)
	);

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	nonce_regs i_nonce_regs (
		.mclk      (mclk),
		.rst       (rst),
		.cur_state (cur_state),
		.trng_trig (trng_trig),
		.success   (success),
		.data_in1  (data_in1),
		.data_in2  (data_in2),
		.trng_in   (trng_in),
		.resp_in   (resp_in),
		.shuf_out  (shuf_out),
		.shuf_done (shuf_done),
		.shuf_data (shuf_data),
		.shuf_key  (shuf_key),
		.data_out  (data_out)
	);

	key_shuffler i_key_shuffler (
		.mclk       (mclk),
		.rst        (rst),
		.shuf_start (shuf_start),
		.deshuffle  (deshuffle),
		.shuf_data  (shuf_data),
		.shuf_key   (shuf_key),
		.shuf_out   (shuf_out),
		.shuf_done  (shuf_done)
	);

	challenge_gen #(.chal_steps(chal_steps)) i_challenge_gen (
		.mclk      (mclk),
		.rst       (rst),
		.cur_state (cur_state),
		.shuf_out  (shuf_out),
		.shuf_done (shuf_done),
		.challenge (challenge),
		.success   (success)
	);

endmodule

/* challenge_gen.sv */
`timescale 1ns/1ns

module challenge_gen #(
	parameter int chal_steps = 1
) (
	input  logic                   mclk,
	input  logic                   rst,
	input  auth_proto_pkg::state_t cur_state,
	input  crypto_pkg::word_t      shuf_out,
	input  logic                   shuf_done,
	output crypto_pkg::word_t      challenge,
	output logic                   success
);
	import auth_proto_pkg::*;
	import crypto_pkg::*;

	localparam int word_w = $bits(word_t);
	localparam int cnt_w  = $clog2(chal_steps + 1);

	logic [cnt_w-1:0] steps_left;		// LFSR steps still owed
	logic             feedback;

	assign feedback = challenge[lfsr_tap0 - 1] ^ challenge[lfsr_tap1 - 1] ^
		challenge[lfsr_tap2 - 1] ^ challenge[lfsr_tap3 - 1];

	////////////////////////////////////////////////////////////
	// Challenge LFSR
	////////////////////////////////////////////////////////////

	always_ff @(posedge mclk or posedge rst)
	begin
		if (rst)
		begin
			challenge  <= '0;
			steps_left <= '0;
		end
		else if ((cur_state == deshuf_chal) && shuf_done)
		begin
			challenge  <= shuf_out;		// Deshuffled seed from the server
			steps_left <= cnt_w'(chal_steps);
		end
		else if ((cur_state == chal_gen) && (steps_left != '0))
		begin
			challenge  <= {challenge[word_w-2:0], feedback};		// Shift left, new bit 0
			steps_left <= steps_left - 1'b1;
		end
	end

	// Server passes when its check word matches our stepped challenge
	assign success = (cur_state == validate) && (challenge == shuf_out);

endmodule

/* crypto_pkg.sv */
package crypto_pkg;

	////////////////////////////////////////////////////////////
	// Data path word
	////////////////////////////////////////////////////////////

	typedef logic [63:0] word_t;		// Nonces, challenge, response and keys

	////////////////////////////////////////////////////////////
	// Keyed shuffler
	////////////////////////////////////////////////////////////

	// One stage per cycle, stage s works on 2^s-bit blocks
	localparam int unsigned shuffle_stages = 6;

	////////////////////////////////////////////////////////////
	// Challenge LFSR, x^64 + x^63 + x^61 + x^60
	////////////////////////////////////////////////////////////

	localparam int unsigned lfsr_tap0 = 64;		// Tap n reads bit n-1
	localparam int unsigned lfsr_tap1 = 63;
	localparam int unsigned lfsr_tap2 = 61;
	localparam int unsigned lfsr_tap3 = 60;

endpackage

/* files.f */
crypto_pkg.sv
auth_proto_pkg.sv
auth_sequencer.sv
nonce_regs.sv
key_shuffler.sv
challenge_gen.sv
auth_top.sv
tb_auth_top.sv

/* key_shuffler.sv */
`timescale 1ns/1ns

module key_shuffler (
	input  logic              mclk,
	input  logic              rst,
	input  logic              shuf_start,
	input  logic              deshuffle,
	input  crypto_pkg::word_t shuf_data,
	input  crypto_pkg::word_t shuf_key,
	output crypto_pkg::word_t shuf_out,
	output logic              shuf_done
);
	import crypto_pkg::*;

	localparam int word_w  = $bits(word_t);
	localparam int stage_w = $clog2(shuffle_stages + 1);
	localparam logic [stage_w-1:0] last_stage = stage_w'(shuffle_stages - 1);

	word_t              key_q;			// Key of the running shuffle
	logic               dir_q;			// Set for deshuffle
	logic               busy;
	logic [stage_w-1:0] stage_cnt;		// Stages done so far
	logic [stage_w-1:0] stage_idx;		// Stage applied this cycle
	word_t              stage_res;

	// Pairwise swap of 2^s-bit blocks
	function automatic word_t swap_blocks(word_t w, logic [stage_w-1:0] s);
		word_t r;
		for (int i = 0; i < word_w; i++)
			r[i] = w[i ^ (1 << s)];		// Partner bit sits in the other block
		return r;
	endfunction

	assign stage_idx = dir_q ? (last_stage - stage_cnt) : stage_cnt;		// Reverse order to undo

	////////////////////////////////////////////////////////////
	// One stage
	////////////////////////////////////////////////////////////

	always_comb
	begin
		if (dir_q)
		begin
			// Rotate right first, then the keyed swap
			stage_res = {shuf_out[0], shuf_out[word_w-1:1]};
			if (key_q[stage_idx])
				stage_res = swap_blocks(stage_res, stage_idx);
		end
		else
		begin
			stage_res = key_q[stage_idx] ? swap_blocks(shuf_out, stage_idx) : shuf_out;
			stage_res = {stage_res[word_w-2:0], stage_res[word_w-1]};		// Rotate left
		end
	end

	// Stage sequencing
	always_ff @(posedge mclk or posedge rst)
	begin
		if (rst)
		begin
			busy      <= 1'b0;
			stage_cnt <= '0;
			shuf_done <= 1'b0;
		end
		else
		begin
			shuf_done <= busy && (stage_cnt == last_stage);		// Result lands with done
			if (shuf_start)
			begin
				busy      <= 1'b1;
				stage_cnt <= '0;
			end
			else if (busy)
			begin
				stage_cnt <= stage_cnt + 1'b1;
				if (stage_cnt == last_stage)
					busy <= 1'b0;
			end
		end
	end

	// Working word, key and direction
	always_ff @(posedge mclk)
	begin
		if (shuf_start)
		begin
			shuf_out <= shuf_data;
			key_q    <= shuf_key;
			dir_q    <= deshuffle;
		end
		else if (busy)
			shuf_out <= stage_res;		// Held after the last stage
	end

	a_fixed_latency: assert property (@(posedge mclk) disable iff (rst)
		shuf_start |-> ##(shuffle_stages + 1) shuf_done);

endmodule

/* nonce_regs.sv */
`timescale 1ns/1ns

module nonce_regs (
	input  logic                   mclk,
	input  logic                   rst,
	input  auth_proto_pkg::state_t cur_state,
	input  logic                   trng_trig,
	input  logic                   success,
	input  crypto_pkg::word_t      data_in1,
	input  crypto_pkg::word_t      data_in2,
	input  crypto_pkg::word_t      trng_in,
	input  crypto_pkg::word_t      resp_in,
	input  crypto_pkg::word_t      shuf_out,
	input  logic                   shuf_done,
	output crypto_pkg::word_t      shuf_data,
	output crypto_pkg::word_t      shuf_key,
	output crypto_pkg::word_t      data_out
);
	import auth_proto_pkg::*;
	import crypto_pkg::*;

	word_t dev_nonce;		// Raw TRNG nonce
	word_t serv_nonce;		// Raw server nonce
	word_t dev_shuf;		// Masks the response and keys the server words
	word_t serv_shuf;		// Keys the response shuffle
	word_t resp_masked;

	////////////////////////////////////////////////////////////
	// Nonce and response capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge mclk)
	begin
		if (trng_trig)
			dev_nonce <= trng_in;
		if (cur_state == wait_serv)
			serv_nonce <= data_in1;		// Last sample is the one under msg_ok
		if (cur_state == puf)
			resp_masked <= resp_in ^ dev_shuf;
		if (shuf_done && (cur_state == shuf_dev))
			dev_shuf <= shuf_out;
		if (shuf_done && (cur_state == shuf_serv))
			serv_shuf <= shuf_out;
	end

	// Shuffler operand and key, ready before shuf_start
	always_ff @(posedge mclk)
	begin
		case (cur_state)
			shuf_dev:
			begin
				shuf_data <= dev_nonce;
				shuf_key  <= dev_nonce;
			end
			shuf_serv:
			begin
				shuf_data <= serv_nonce;
				shuf_key  <= serv_nonce;
			end
			deshuf_chal:
			begin
				shuf_data <= data_in1;		// Shuffled challenge seed
				shuf_key  <= dev_shuf;
			end
			deshuf_check:
			begin
				shuf_data <= data_in2;		// Shuffled check word
				shuf_key  <= dev_shuf;
			end
			shuf_resp:
			begin
				shuf_data <= resp_masked;
				shuf_key  <= serv_shuf;
			end
			default: ;
		endcase
	end

	// Output word to the processor
	always_ff @(posedge mclk or posedge rst)
	begin
		if (rst)
			data_out <= init_packet;
		else if (cur_state == idle)
			data_out <= init_packet;
		else if (trng_trig)
			data_out <= trng_in;		// Device nonce
		else if (success)
			data_out <= success_word;
		else if ((cur_state == shuf_resp) && shuf_done)
			data_out <= shuf_out;		// Final response
	end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the auth_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_auth_top -f files.f -o tb_auth_top_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_auth_top_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'RESULT: PASS'; then
	exit 0
fi
exit 1

/* tb_auth_top.sv */
`timescale 1ns/1ns

module tb_auth_top;
	import auth_proto_pkg::*;
	import crypto_pkg::*;

	localparam int chal_steps     = 3;		// LFSR steps per challenge, passed to the DUT
	localparam int clk_period     = 10;
	localparam int partner_delay  = 3;		// TRNG and PUF answer time in cycles
	localparam int session_cycles = 150;	// Generous bound for one session
	localparam int n_full         = 3;
	localparam int n_sessions     = n_full + 3;		// Plus bad check, abort and recovery

	logic   mclk = 1'b0;
	logic   rst;
	logic   en;
	msg_t   ps_msg;
	word_t  data_in1;
	word_t  data_in2;
	word_t  resp_in;
	word_t  trng_in;
	logic   puf_done;
	logic   puf_en;
	logic   trng_trig;
	logic   interrupt1;
	logic   interrupt2;
	word_t  challenge;
	word_t  data_out;

	logic [31:0] rng_state = 32'hfb19;
	int          errors    = 0;
	int          checks    = 0;
	int          tests     = 0;
	int          int1_count = 0;	// Pulses seen by the monitor
	int          int2_count = 0;
	int          puf_count  = 0;
	string       cur_test;
	string       int2_what;			// Which word interrupt2 should show
	word_t       exp_int2;
	word_t       exp_chal;

	always #(clk_period / 2) mclk = ~mclk;

	auth_top #(.chal_steps(chal_steps)) i_auth_top (
		.mclk       (mclk),
		.rst        (rst),
		.en         (en),
		.ps_msg     (ps_msg),
		.data_in1   (data_in1),
		.data_in2   (data_in2),
		.resp_in    (resp_in),
		.trng_in    (trng_in),
		.puf_done   (puf_done),
		.puf_en     (puf_en),
		.trng_trig  (trng_trig),
		.interrupt1 (interrupt1),
		.interrupt2 (interrupt2),
		.challenge  (challenge),
		.data_out   (data_out)
	);

	////////////////////////////////////////////////////////////
	// Random words and reference model
	////////////////////////////////////////////////////////////

	// x^32 + x^22 + x^2 + x^1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic word_t rand_word();
		word_t w;
		w = '0;
		for (int i = 0; i < 64; i++)
		begin
			rng_state = lfsr_step(rng_state);		// One step per bit
			w = {w[62:0], rng_state[0]};
		end
		return w;
	endfunction

	// Exchange neighbouring blocks of 2^s bits
	function automatic word_t swap_pairs(word_t w, int s);
		word_t r;
		int    sz;
		r  = w;
		sz = 1 << s;
		for (int b = 0; b < 64; b = b + 2 * sz)
			for (int k = 0; k < sz; k++)
			begin
				r[b + k]      = w[b + sz + k];
				r[b + sz + k] = w[b + k];
			end
		return r;
	endfunction

	function automatic word_t ref_shuffle(word_t d, word_t key);
		word_t w;
		w = d;
		for (int s = 0; s < int'(shuffle_stages); s++)
		begin
			if (key[s])
				w = swap_pairs(w, s);
			w = {w[62:0], w[63]};		// Rotate left by one
		end
		return w;
	endfunction

	function automatic word_t ref_deshuffle(word_t d, word_t key);
		word_t w;
		w = d;
		for (int s = int'(shuffle_stages) - 1; s >= 0; s--)
		begin
			w = {w[0], w[63:1]};		// Undo the rotation first
			if (key[s])
				w = swap_pairs(w, s);
		end
		return w;
	endfunction

	// Taps 64, 63, 61, 60
	function automatic word_t ref_lfsr(word_t seed, int n);
		word_t w;
		w = seed;
		for (int i = 0; i < n; i++)
			w = {w[62:0], w[63] ^ w[62] ^ w[60] ^ w[59]};
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// Checks and waits
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic wait_interrupt2(input string test);
		int n;
		n = 0;
		@(negedge mclk);
		while (!interrupt2 && n < session_cycles)
		begin
			@(negedge mclk);
			n++;
		end
		if (!interrupt2)
		begin
			$display("%s: interrupt2 did not arrive within %0d cycles", test, session_cycles);
			errors++;
		end
	endtask

	task automatic wait_data_out(input string test, input word_t target);
		int n;
		n = 0;
		@(negedge mclk);
		while (data_out !== target && n < session_cycles)
		begin
			@(negedge mclk);
			n++;
		end
		if (data_out !== target)
		begin
			$display("%s: data_out never showed %h within %0d cycles", test, target,
				session_cycles);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_snap);
		tests++;
		if (errors == err_snap)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_snap);
	endtask

	////////////////////////////////////////////////////////////
	// Sessions
	////////////////////////////////////////////////////////////

	// Full session; corrupt spoils the check word so validation fails
	task automatic run_session(input string name, input bit corrupt);
		word_t nonce;
		word_t serv;
		word_t seed;
		word_t resp;
		word_t dev_shuf;
		word_t serv_shuf;
		word_t chal_word;
		word_t check_word;
		int    err_snap;
		int    i1_snap;
		int    i2_snap;
		int    puf_snap;
		err_snap = errors;
		nonce = rand_word();
		serv  = rand_word();
		seed  = rand_word();
		resp  = rand_word();
		if (nonce == init_packet)
			nonce = ~nonce;		// data_out must leave the idle word
		dev_shuf   = ref_shuffle(nonce, nonce);
		serv_shuf  = ref_shuffle(serv, serv);
		chal_word  = ref_shuffle(seed, dev_shuf);		// Server side encoding
		check_word = ref_shuffle(ref_lfsr(seed, chal_steps), dev_shuf);
		if (corrupt)
			check_word[0] = ~check_word[0];
		cur_test  = name;
		int2_what = "nonce";
		exp_int2  = nonce;
		exp_chal  = ref_lfsr(ref_deshuffle(chal_word, dev_shuf), chal_steps);
		i1_snap   = int1_count;
		i2_snap   = int2_count;
		puf_snap  = puf_count;
		trng_in   = nonce;
		resp_in   = resp;
		data_in1  = serv;				// Server nonce waits for wait_serv
		ps_msg    = msg_ok;
		en = 1'b1;
		@(negedge mclk);
		en = 1'b0;
		wait_interrupt2(name);			// Device nonce is out
		ps_msg   = 2'b00;				// Hold in wait_chal while the server answers
		data_in1 = chal_word;
		data_in2 = check_word;
		repeat (3) @(negedge mclk);
		int2_what = "response";
		exp_int2  = ref_shuffle(resp ^ dev_shuf, serv_shuf);
		ps_msg    = msg_ok;
		if (!corrupt)
			wait_interrupt2(name);
		wait_data_out(name, init_packet);		// Back in idle
		ps_msg = 2'b00;
		check_value({name, " interrupt1 pulses"}, word_t'(2), word_t'(int1_count - i1_snap));
		check_value({name, " interrupt2 pulses"}, corrupt ? word_t'(1) : word_t'(2),
			word_t'(int2_count - i2_snap));
		check_value({name, " puf_en pulses"}, corrupt ? word_t'(0) : word_t'(1),
			word_t'(puf_count - puf_snap));
		repeat (2) @(negedge mclk);
		report_test(name, err_snap);
	endtask

	// Abort while the controller waits for the server nonce
	task automatic run_abort(input string name);
		word_t nonce;
		int    err_snap;
		int    i1_snap;
		int    i2_snap;
		err_snap = errors;
		nonce = rand_word();
		if (nonce == init_packet)
			nonce = ~nonce;
		cur_test = name;
		i1_snap  = int1_count;
		i2_snap  = int2_count;
		trng_in  = nonce;
		ps_msg   = msg_abort;		// Ignored until wait_serv
		en = 1'b1;
		@(negedge mclk);
		en = 1'b0;
		wait_data_out(name, nonce);
		wait_data_out(name, init_packet);
		ps_msg = 2'b00;
		repeat (5) @(negedge mclk);
		check_value({name, " idle data_out"}, init_packet, data_out);
		check_value({name, " interrupt1 pulses"}, word_t'(1), word_t'(int1_count - i1_snap));
		check_value({name, " interrupt2 pulses"}, word_t'(0), word_t'(int2_count - i2_snap));
		report_test(name, err_snap);
	endtask

	////////////////////////////////////////////////////////////
	// TRNG and PUF partner, monitor, watchdog
	////////////////////////////////////////////////////////////

	// Both partners answer on the shared done line
	initial
	begin
		puf_done = 1'b0;
		forever
		begin
			@(negedge mclk);
			if (trng_trig || puf_en)
			begin
				repeat (partner_delay) @(negedge mclk);
				puf_done = 1'b1;
				@(negedge mclk);
				puf_done = 1'b0;
			end
		end
	end

	// Compares output words on the pulses
	initial
	begin
		forever
		begin
			@(negedge mclk);
			if (!rst)
			begin
				if (interrupt1)
					int1_count++;
				if (interrupt2)
				begin
					check_value({cur_test, " ", int2_what}, exp_int2, data_out);
					int2_count++;
				end
				if (puf_en)
				begin
					check_value({cur_test, " challenge"}, exp_chal, challenge);
					check_value({cur_test, " success word"}, success_word, data_out);
					puf_count++;
				end
			end
		end
	end

	initial
	begin
		#((n_sessions + 2) * session_cycles * clk_period);
		$display("Watchdog expired before the tests completed");
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		rst      = 1'b1;
		en       = 1'b0;
		ps_msg   = 2'b00;
		data_in1 = '0;
		data_in2 = '0;
		resp_in  = '0;
		trng_in  = '0;
		cur_test  = "reset";
		int2_what = "nonce";
		exp_int2  = '0;
		exp_chal  = '0;
		repeat (2) @(negedge mclk);
		rst = 1'b0;
		check_value("reset data_out", init_packet, data_out);
		check_value("reset interrupt1", word_t'(0), word_t'(interrupt1));
		check_value("reset interrupt2", word_t'(0), word_t'(interrupt2));
		check_value("reset puf_en", word_t'(0), word_t'(puf_en));
		check_value("reset trng_trig", word_t'(0), word_t'(trng_trig));
		report_test("reset", 0);
		repeat (2) @(negedge mclk);
		for (int i = 0; i < n_full; i++)
			run_session($sformatf("session_%0d", i), 1'b0);
		run_session("bad_check", 1'b1);
		run_abort("abort_serv");
		run_session("after_abort", 1'b0);		// Controller recovers
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
